/* all.f */
src/rv_core_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_commit.sv
src/rv_core.sv
verification/rv_core_props.sv
verification/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

{ verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
	-f all.f -o sim_rv_core && ./obj_dir/sim_rv_core; } > sim.log 2>&1 \
	|| echo "simulation did not complete" >> sim.log

cat sim.log
grep -qF '** FAIL **' sim.log && exit 1
grep -qF 'simulation did not complete' sim.log && exit 1
grep -qF '** PASS **' sim.log || exit 1
exit 0

/* src/rv_commit.sv */
`timescale 1ns/1ps

module rv_commit import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic wb_valid,
	input addr_t wb_pc,
	input inst_t wb_inst,
	input logic wb_wen,
	input reg_index_t wb_rdest,
	input xlen_t wb_wdata,
	input logic wb_is_trap,
	input xlen_t a0_value,
	output logic commit_valid,
	output addr_t commit_pc,
	output inst_t commit_inst,
	output logic commit_wen,
	output reg_index_t commit_rdest,
	output xlen_t commit_wdata,
	output logic trap,
	output logic [7:0] trap_code,
	output xlen_t cycle_count,
	output xlen_t instr_count
);

	logic retire;

	assign retire = wb_valid && !trap; // nothing retires past a trap

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
			commit_wen <= 1'b0;
			trap <= 1'b0;
			trap_code <= '0;
			cycle_count <= '0;
			instr_count <= '0;
		end else begin
			commit_valid <= retire;
			commit_wen <= retire && wb_wen && wb_rdest != '0;
			if (retire && wb_is_trap) begin
				trap <= 1'b1; // held until reset
				trap_code <= a0_value[7:0];
			end
			if (!trap)
				cycle_count <= cycle_count + 64'd1;
			if (retire)
				instr_count <= instr_count + 64'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			commit_pc <= wb_pc;
			commit_inst <= wb_inst;
			commit_rdest <= wb_rdest;
			commit_wdata <= wb_wdata;
		end
	end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
	parameter addr_t reset_vector = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	output logic ar_valid,
	output addr_t ar_addr,
	input logic ar_ready,
	input logic r_valid,
	input inst_t r_data,
	output logic commit_valid,
	output addr_t commit_pc,
	output inst_t commit_inst,
	output logic commit_wen,
	output reg_index_t commit_rdest,
	output xlen_t commit_wdata,
	output logic trap,
	output logic [7:0] trap_code,
	output xlen_t cycle_count,
	output xlen_t instr_count
);

	logic fetch_valid;
	addr_t fetch_pc;
	inst_t fetch_inst;
	logic redirect;
	addr_t redirect_pc;
	logic ex_valid;
	addr_t ex_pc;
	inst_t ex_inst;
	alu_op_t ex_alu_op;
	xlen_t ex_operand_a;
	xlen_t ex_operand_b;
	xlen_t ex_rs2_value;
	logic ex_branch;
	logic ex_branch_ne;
	logic ex_jump;
	addr_t ex_target;
	logic ex_wen;
	reg_index_t ex_rdest;
	logic ex_is_trap;
	xlen_t ex_result;
	logic wb_valid;
	addr_t wb_pc;
	inst_t wb_inst;
	logic wb_wen;
	reg_index_t wb_rdest;
	xlen_t wb_wdata;
	logic wb_is_trap;
	xlen_t a0_value;

	rv_fetch #(
		.reset_vector(reset_vector)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r_data(r_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.trap(trap),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst)
	);

	rv_decode u_decode (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst),
		.redirect(redirect),
		.ex_result(ex_result),
		.wb_valid(wb_valid),
		.wb_wen(wb_wen),
		.wb_rdest(wb_rdest),
		.wb_wdata(wb_wdata),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_inst(ex_inst),
		.ex_alu_op(ex_alu_op),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.ex_rs2_value(ex_rs2_value),
		.ex_branch(ex_branch),
		.ex_branch_ne(ex_branch_ne),
		.ex_jump(ex_jump),
		.ex_target(ex_target),
		.ex_wen(ex_wen),
		.ex_rdest(ex_rdest),
		.ex_is_trap(ex_is_trap),
		.a0_value(a0_value)
	);

	rv_execute u_execute (
		.clock(clock),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_inst(ex_inst),
		.ex_alu_op(ex_alu_op),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.ex_rs2_value(ex_rs2_value),
		.ex_branch(ex_branch),
		.ex_branch_ne(ex_branch_ne),
		.ex_jump(ex_jump),
		.ex_target(ex_target),
		.ex_wen(ex_wen),
		.ex_rdest(ex_rdest),
		.ex_is_trap(ex_is_trap),
		.ex_result(ex_result),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.wb_valid(wb_valid),
		.wb_pc(wb_pc),
		.wb_inst(wb_inst),
		.wb_wen(wb_wen),
		.wb_rdest(wb_rdest),
		.wb_wdata(wb_wdata),
		.wb_is_trap(wb_is_trap)
	);

	rv_commit u_commit (
		.clock(clock),
		.reset(reset),
		.wb_valid(wb_valid),
		.wb_pc(wb_pc),
		.wb_inst(wb_inst),
		.wb_wen(wb_wen),
		.wb_rdest(wb_rdest),
		.wb_wdata(wb_wdata),
		.wb_is_trap(wb_is_trap),
		.a0_value(a0_value),
		.commit_valid(commit_valid),
		.commit_pc(commit_pc),
		.commit_inst(commit_inst),
		.commit_wen(commit_wen),
		.commit_rdest(commit_rdest),
		.commit_wdata(commit_wdata),
		.trap(trap),
		.trap_code(trap_code),
		.cycle_count(cycle_count),
		.instr_count(instr_count)
	);

endmodule

/* src/rv_core_pkg.sv */
package rv_core_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [63:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_index_t;

	// major opcodes of the supported subset
	localparam logic [6:0] op_reg    = 7'h33; // add sub and or xor
	localparam logic [6:0] op_imm    = 7'h13; // addi only
	localparam logic [6:0] op_lui    = 7'h37;
	localparam logic [6:0] op_branch = 7'h63; // beq bne
	localparam logic [6:0] op_jal    = 7'h6f;
	localparam logic [6:0] op_trap   = 7'h6b; // halts the core, code in x10

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b // lui immediate and jal link
	} alu_op_t;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_request,
		fetch_wait
	} fetch_state_t;

endpackage

/* src/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input addr_t fetch_pc,
	input inst_t fetch_inst,
	input logic redirect,
	input xlen_t ex_result,
	input logic wb_valid,
	input logic wb_wen,
	input reg_index_t wb_rdest,
	input xlen_t wb_wdata,
	output logic ex_valid,
	output addr_t ex_pc,
	output inst_t ex_inst,
	output alu_op_t ex_alu_op,
	output xlen_t ex_operand_a,
	output xlen_t ex_operand_b,
	output xlen_t ex_rs2_value,
	output logic ex_branch,
	output logic ex_branch_ne,
	output logic ex_jump,
	output addr_t ex_target,
	output logic ex_wen,
	output reg_index_t ex_rdest,
	output logic ex_is_trap,
	output xlen_t a0_value
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_index_t rs1;
	reg_index_t rs2;
	reg_index_t rd;
	xlen_t imm_i;
	xlen_t imm_u;
	xlen_t imm_b;
	xlen_t imm_j;
	xlen_t rf_rs1;
	xlen_t rf_rs2;
	xlen_t rs1_value;
	xlen_t rs2_value;
	xlen_t operand_b;
	alu_op_t alu_op;
	logic writes_rd;
	logic is_branch;
	logic is_jump;
	logic is_trap;
	addr_t target;

	assign opcode = fetch_inst[6:0];
	assign rd = fetch_inst[11:7];
	assign funct3 = fetch_inst[14:12];
	assign rs1 = fetch_inst[19:15];
	assign rs2 = fetch_inst[24:20];
	assign funct7 = fetch_inst[31:25];

	assign imm_i = {{52{fetch_inst[31]}}, fetch_inst[31:20]};
	assign imm_u = {{32{fetch_inst[31]}}, fetch_inst[31:12], 12'b0};
	assign imm_b = {{52{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
		fetch_inst[11:8], 1'b0};
	assign imm_j = {{44{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
		fetch_inst[30:21], 1'b0};

	rv_regfile u_regfile (
		.clock(clock),
		.reset(reset),
		.rs1_index(rs1),
		.rs2_index(rs2),
		.write_enable(wb_valid && wb_wen),
		.write_index(wb_rdest),
		.write_data(wb_wdata),
		.rs1_value(rf_rs1),
		.rs2_value(rf_rs2),
		.a0_value(a0_value)
	);

	// execute result first, then the value being written back
	function automatic xlen_t forward(input reg_index_t index, input xlen_t rf_value);
		if (index == '0)
			return '0;
		if (ex_valid && ex_wen && ex_rdest == index)
			return ex_result;
		if (wb_valid && wb_wen && wb_rdest == index)
			return wb_wdata;
		return rf_value;
	endfunction

	assign rs1_value = forward(rs1, rf_rs1);
	assign rs2_value = forward(rs2, rf_rs2);

	always_comb begin
		alu_op = alu_add;
		operand_b = rs2_value;
		writes_rd = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		is_trap = 1'b0;
		target = fetch_pc + imm_b;
		case (opcode)
			op_reg: begin
				if (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
					writes_rd = 1'b1;
					case (funct3)
						3'b000: alu_op = funct7[5] ? alu_sub : alu_add;
						3'b100: alu_op = alu_xor;
						3'b110: alu_op = alu_or;
						3'b111: alu_op = alu_and;
						default: writes_rd = 1'b0; // shifts and compares are no-ops
					endcase
				end
			end
			op_imm: begin
				if (funct3 == 3'b000) begin
					operand_b = imm_i;
					writes_rd = 1'b1;
				end
			end
			op_lui: begin
				alu_op = alu_pass_b;
				operand_b = imm_u;
				writes_rd = 1'b1;
			end
			op_branch: is_branch = (funct3[2:1] == 2'b00); // beq or bne
			op_jal: begin
				alu_op = alu_pass_b;
				operand_b = fetch_pc + 64'd4; // link value
				target = fetch_pc + imm_j;
				writes_rd = 1'b1;
				is_jump = 1'b1;
			end
			op_trap: is_trap = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= fetch_valid && !redirect; // younger than a taken branch
	end

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			ex_pc <= fetch_pc;
			ex_inst <= fetch_inst;
			ex_alu_op <= alu_op;
			ex_operand_a <= rs1_value;
			ex_operand_b <= operand_b;
			ex_rs2_value <= rs2_value;
			ex_branch <= is_branch;
			ex_branch_ne <= funct3[0];
			ex_jump <= is_jump;
			ex_target <= target;
			ex_wen <= writes_rd;
			ex_rdest <= rd;
			ex_is_trap <= is_trap;
		end
	end

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic ex_valid,
	input addr_t ex_pc,
	input inst_t ex_inst,
	input alu_op_t ex_alu_op,
	input xlen_t ex_operand_a,
	input xlen_t ex_operand_b,
	input xlen_t ex_rs2_value,
	input logic ex_branch,
	input logic ex_branch_ne,
	input logic ex_jump,
	input addr_t ex_target,
	input logic ex_wen,
	input reg_index_t ex_rdest,
	input logic ex_is_trap,
	output xlen_t ex_result,
	output logic redirect,
	output addr_t redirect_pc,
	output logic wb_valid,
	output addr_t wb_pc,
	output inst_t wb_inst,
	output logic wb_wen,
	output reg_index_t wb_rdest,
	output xlen_t wb_wdata,
	output logic wb_is_trap
);

	logic operands_equal;
	logic branch_taken;

	always_comb begin
		case (ex_alu_op)
			alu_add: ex_result = ex_operand_a + ex_operand_b;
			alu_sub: ex_result = ex_operand_a - ex_operand_b;
			alu_and: ex_result = ex_operand_a & ex_operand_b;
			alu_or: ex_result = ex_operand_a | ex_operand_b;
			alu_xor: ex_result = ex_operand_a ^ ex_operand_b;
			alu_pass_b: ex_result = ex_operand_b;
			default: ex_result = '0;
		endcase
	end

	assign operands_equal = (ex_operand_a == ex_rs2_value);
	assign branch_taken = ex_branch && (operands_equal != ex_branch_ne);

	// fetch and decode flush on this in the same cycle
	assign redirect = ex_valid && (branch_taken || ex_jump);
	assign redirect_pc = ex_target;

	always_ff @(posedge clock) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid;
	end

	always_ff @(posedge clock) begin
		if (ex_valid) begin
			wb_pc <= ex_pc;
			wb_inst <= ex_inst;
			wb_wen <= ex_wen;
			wb_rdest <= ex_rdest;
			wb_wdata <= ex_result;
			wb_is_trap <= ex_is_trap;
		end
	end

endmodule

/* src/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch import rv_core_pkg::*; #(
	parameter addr_t reset_vector = 64'h8000_0000
) (
	input logic clock,
	input logic reset,
	input logic ar_ready,
	input logic r_valid,
	input inst_t r_data,
	input logic redirect,
	input addr_t redirect_pc,
	input logic trap,
	output logic ar_valid,
	output addr_t ar_addr,
	output logic fetch_valid,
	output addr_t fetch_pc,
	output inst_t fetch_inst
);

	fetch_state_t state;
	addr_t pc; // address of the request in flight
	addr_t redirect_target;
	logic stale; // response in flight belongs to a flushed path

	assign ar_valid = (state == fetch_request);
	assign ar_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_idle;
			pc <= reset_vector;
			stale <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;
			case (state)
				fetch_idle: begin
					// only reached from reset or after a trap
					if (!trap)
						state <= fetch_request;
				end
				fetch_request: begin
					if (redirect)
						stale <= 1'b1; // address must hold until accepted
					if (ar_ready)
						state <= fetch_wait;
				end
				fetch_wait: begin
					if (r_valid) begin
						fetch_valid <= !stale && !redirect && !trap;
						stale <= 1'b0;
						if (redirect)
							pc <= redirect_pc;
						else if (stale)
							pc <= redirect_target;
						else
							pc <= pc + 64'd4;
						state <= trap ? fetch_idle : fetch_request;
					end else if (redirect) begin
						stale <= 1'b1;
					end
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	// latest redirect wins
	always_ff @(posedge clock) begin
		if (redirect)
			redirect_target <= redirect_pc;
	end

	always_ff @(posedge clock) begin
		if (state == fetch_wait && r_valid) begin
			fetch_pc <= pc;
			fetch_inst <= r_data;
		end
	end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input reg_index_t rs1_index,
	input reg_index_t rs2_index,
	input logic write_enable,
	input reg_index_t write_index,
	input xlen_t write_data,
	output xlen_t rs1_value,
	output xlen_t rs2_value,
	output xlen_t a0_value
);

	xlen_t regs [0:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_enable && write_index != '0) begin
			regs[write_index] <= write_data; // x0 stays zero
		end
	end

	assign rs1_value = regs[rs1_index];
	assign rs2_value = regs[rs2_index];
	assign a0_value = regs[10]; // trap code source

endmodule

/* verification/rv_core_props.sv */
`timescale 1ns/1ps

module rv_core_props import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	input addr_t ar_addr,
	input logic ar_ready,
	input logic r_valid,
	input logic commit_valid,
	input logic trap
);

	logic outstanding; // accepted request still waiting for data

	always_ff @(posedge clock) begin
		if (reset)
			outstanding <= 1'b0;
		else if (ar_valid && ar_ready)
			outstanding <= 1'b1;
		else if (r_valid)
			outstanding <= 1'b0;
	end

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else $error("fetch request dropped or changed before accept");

	one_outstanding: assert property (@(posedge clock) disable iff (reset)
		outstanding |-> !ar_valid)
		else $error("fetch request while a response is outstanding");

	trap_with_commit: assert property (@(posedge clock) disable iff (reset)
		$rose(trap) |-> commit_valid)
		else $error("trap rose without a commit");

	quiet_after_trap: assert property (@(posedge clock) disable iff (reset)
		trap && $past(trap) |-> !commit_valid && !$rose(ar_valid))
		else $error("activity after trap");

endmodule

bind rv_core rv_core_props u_props (
	.clock(clock),
	.reset(reset),
	.ar_valid(ar_valid),
	.ar_addr(ar_addr),
	.ar_ready(ar_ready),
	.r_valid(r_valid),
	.commit_valid(commit_valid),
	.trap(trap)
);

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*;;

	localparam addr_t base = 64'h8000_0000;
	localparam inst_t poison = 32'hfff0_0f93; // addi x31, x0, -1

	logic clock;
	logic reset = 1'b1;
	logic ar_ready = 1'b0;
	logic r_valid = 1'b0;
	inst_t r_data = '0;
	logic ar_valid;
	addr_t ar_addr;
	logic commit_valid;
	addr_t commit_pc;
	inst_t commit_inst;
	logic commit_wen;
	reg_index_t commit_rdest;
	xlen_t commit_wdata;
	logic trap;
	logic [7:0] trap_code;
	xlen_t cycle_count;
	xlen_t instr_count;

	inst_t program_mem [0:31];
	integer seed = 32'h23ce;
	logic [1:0] mem_phase = 2'd0;
	int delay = 0;
	int elapsed = 0; // clock cycles since reset release
	addr_t req_addr;
	addr_t exp_pc [$];
	inst_t exp_inst [$];
	logic exp_wen [$];
	xlen_t exp_wdata [$];
	xlen_t ref_x10;

	rv_core #(.reset_vector(base)) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic inst_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
	endfunction

	function automatic inst_t enc_i(input int imm, input int rs1, input int rd);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), op_imm};
	endfunction

	function automatic inst_t enc_b(input int off, input int rs2, input int rs1,
		input logic [2:0] f3);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], op_branch};
	endfunction

	function automatic inst_t enc_j(input int off, input int rd);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), op_jal};
	endfunction

	function automatic inst_t fetch_word(input addr_t addr);
		addr_t index;
		index = (addr - base) >> 2;
		if (addr < base || index > 31)
			return poison;
		return program_mem[index[4:0]];
	endfunction

	task automatic load_program();
		for (int i = 0; i < 32; i++)
			program_mem[i] = poison;
		program_mem[0] = enc_i(5, 0, 1);
		program_mem[1] = enc_i(7, 1, 2); // chained on x1
		program_mem[2] = enc_r(7'h00, 2, 1, 3'b000, 3);
		program_mem[3] = enc_r(7'h20, 1, 3, 3'b000, 4);
		program_mem[4] = enc_r(7'h00, 3, 4, 3'b100, 5);
		program_mem[5] = enc_r(7'h00, 3, 5, 3'b111, 6);
		program_mem[6] = enc_r(7'h00, 1, 6, 3'b110, 7);
		program_mem[7] = enc_i(9, 1, 0); // x0 write
		program_mem[8] = enc_r(7'h00, 1, 0, 3'b000, 8);
		program_mem[9] = {20'h12345, 5'd9, op_lui};
		program_mem[10] = enc_r(7'h00, 1, 9, 3'b000, 9);
		program_mem[11] = enc_b(8, 4, 2, 3'b000); // beq taken
		program_mem[13] = enc_b(8, 2, 1, 3'b001); // bne taken
		program_mem[15] = enc_b(8, 2, 1, 3'b000);
		program_mem[16] = enc_b(8, 4, 2, 3'b001);
		program_mem[17] = enc_j(8, 11);
		program_mem[19] = enc_i(42, 9, 10);
		program_mem[20] = {25'd0, op_trap};
	endtask

	// instruction set model of the program, one commit per step
	task automatic build_reference();
		xlen_t x [0:31];
		addr_t pc;
		inst_t w;
		xlen_t a;
		xlen_t b;
		xlen_t result;
		logic writes;
		addr_t next_pc;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		pc = base;
		for (int step = 0; step < 100; step++) begin
			w = fetch_word(pc);
			a = x[w[19:15]];
			b = x[w[24:20]];
			writes = 1'b0;
			result = '0;
			next_pc = pc + 4;
			case (w[6:0])
				op_reg: begin
					writes = 1'b1;
					case ({w[31:25], w[14:12]})
						10'b0000000_000: result = a + b;
						10'b0100000_000: result = a - b;
						10'b0000000_100: result = a ^ b;
						10'b0000000_110: result = a | b;
						10'b0000000_111: result = a & b;
						default: writes = 1'b0;
					endcase
				end
				op_imm: begin
					writes = (w[14:12] == 3'b000);
					result = a + {{52{w[31]}}, w[31:20]};
				end
				op_lui: begin
					writes = 1'b1;
					result = {{32{w[31]}}, w[31:12], 12'b0};
				end
				op_branch: begin
					if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b))
						next_pc = pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
				op_jal: begin
					writes = 1'b1;
					result = pc + 4;
					next_pc = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				end
				default: ;
			endcase
			exp_pc.push_back(pc);
			exp_inst.push_back(w);
			exp_wen.push_back(writes && w[11:7] != 0);
			exp_wdata.push_back(result);
			if (writes && w[11:7] != 0)
				x[w[11:7]] = result;
			if (w[6:0] == op_trap)
				break;
			pc = next_pc;
		end
		ref_x10 = x[10];
	endtask

	// memory answers each strobe after 0 to 3 idle cycles
	always @(posedge clock) begin : memory_model
		int latency;
		r_valid <= 1'b0;
		if (reset) begin
			ar_ready <= 1'b0;
			mem_phase <= 2'd0;
			delay <= 0;
		end else if (mem_phase == 2'd0) begin
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				latency = $random(seed) & 3;
				if (latency == 0) begin
					r_valid <= 1'b1; // data in the cycle right after the accept
					r_data <= fetch_word(ar_addr);
					delay <= $random(seed) & 3;
				end else begin
					req_addr <= ar_addr;
					delay <= latency;
					mem_phase <= 2'd1;
				end
			end else if (delay == 0) begin
				ar_ready <= 1'b1; // ready may lead valid
			end else if (ar_valid) begin
				if (delay == 1)
					ar_ready <= 1'b1;
				delay <= delay - 1;
			end
		end else begin
			if (delay == 1) begin
				r_valid <= 1'b1;
				r_data <= fetch_word(req_addr);
				delay <= $random(seed) & 3;
				mem_phase <= 2'd0;
			end else begin
				delay <= delay - 1;
			end
		end
	end

	task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
		assert (actual === expected) else begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_idle_outputs();
		check_value("ar_valid", 0, ar_valid);
		check_value("commit_valid", 0, commit_valid);
		check_value("commit_wen", 0, commit_wen);
		check_value("trap", 0, trap);
		check_value("cycle_count", 0, cycle_count);
		check_value("instr_count", 0, instr_count);
	endtask

	task automatic wait_commit();
		int cycles;
		cycles = 0;
		@(negedge clock);
		elapsed++;
		while (commit_valid !== 1'b1) begin
			cycles++;
			if (cycles > 200) begin
				$display("** FAIL **");
				$fatal(1, "timed out waiting for a commit");
			end
			@(negedge clock);
			elapsed++;
		end
	endtask

	initial begin
		load_program();
		build_reference();
		repeat (2) begin
			@(negedge clock);
			check_idle_outputs();
		end
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_idle_outputs();
		for (int i = 0; i < exp_pc.size(); i++) begin
			wait_commit();
			check_value("commit_pc", exp_pc[i], commit_pc);
			check_value("commit_inst", exp_inst[i], commit_inst);
			check_value("commit_rdest", exp_inst[i][11:7], commit_rdest);
			check_value("commit_wen", exp_wen[i], commit_wen);
			if (exp_wen[i])
				check_value("commit_wdata", exp_wdata[i], commit_wdata);
			assert (commit_inst != poison) else begin
				$display("** FAIL **");
				$fatal(1, "an instruction on a flushed path committed");
			end
			check_value("trap", exp_inst[i][6:0] == op_trap, trap);
		end
		check_value("trap_code", ref_x10[7:0], trap_code);
		check_value("instr_count", exp_pc.size(), instr_count);
		check_value("cycle_count", elapsed, cycle_count);
		repeat (20) begin
			@(negedge clock);
			check_value("commit_valid", 0, commit_valid);
		end
		check_value("cycle_count", elapsed, cycle_count); // frozen since the trap
		check_value("ar_valid", 0, ar_valid); // in-flight fetch has drained
		$display("** PASS **");
		$finish;
	end

endmodule
